/* verification/mem_test_input.txt */
# columns (hex): test, blocks to observe, max ready delay,
# corrupt block (ff = none), corrupt beat index
1 2 0 ff 0
2 3 4 ff 0
3 2 3 1 5
4 1 0 0 0
5 3 7 ff 0
6 2 2 1 f

/* build.f */
+incdir+source
source/mem_test_pkg.sv
source/amci_if.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/block_checker.sv
source/mem_test_top.sv
verification/mem_test_props.sv
verification/tb_mem_test.sv

/* Bender.yml */
package:
  name: mem_test

sources:
  - include_dirs:
      - source
    files:
      - source/mem_test_pkg.sv
      - source/amci_if.sv
      - source/axi_write_engine.sv
      - source/axi_read_engine.sv
      - source/block_checker.sv
      - source/mem_test_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - verification/mem_test_props.sv
      - verification/tb_mem_test.sv

/* verification/tb_mem_test.sv */
`timescale 1ns/1ps

`include "mem_test_cfg.svh"

module tb_mem_test;
    import mem_test_pkg::*;

    localparam int BS = `MT_BLOCK_SIZE;

    logic  clk;
    logic  M_AXI_ARESETN;
    logic  button;
    logic  alarm;
    addr_t m_axi_awaddr;
    logic  m_axi_awvalid;
    logic  m_axi_awready;
    logic [2:0] m_axi_awprot;
    logic [3:0] m_axi_awid;
    logic [7:0] m_axi_awlen;
    logic [2:0] m_axi_awsize;
    logic [1:0] m_axi_awburst;
    logic  m_axi_awlock;
    logic [3:0] m_axi_awcache;
    logic [3:0] m_axi_awqos;
    data_t m_axi_wdata;
    strb_t m_axi_wstrb;
    logic  m_axi_wvalid;
    logic  m_axi_wlast;
    logic  m_axi_wready;
    logic [1:0] m_axi_bresp;
    logic  m_axi_bvalid;
    logic  m_axi_bready;
    addr_t m_axi_araddr;
    logic  m_axi_arvalid;
    logic  m_axi_arready;
    logic [2:0] m_axi_arprot;
    logic [3:0] m_axi_arid;
    logic [7:0] m_axi_arlen;
    logic [2:0] m_axi_arsize;
    logic [1:0] m_axi_arburst;
    logic  m_axi_arlock;
    logic [3:0] m_axi_arcache;
    logic [3:0] m_axi_arqos;
    data_t m_axi_rdata;
    logic [1:0] m_axi_rresp;
    logic  m_axi_rvalid;
    logic  m_axi_rlast;
    logic  m_axi_rready;

    // Slave model state
    data_t       mem [addr_t];
    addr_t       aw_q [$];
    data_t       w_q [$];
    addr_t       ar_q [$];
    addr_t       blk_addr [BS];
    data_t       blk_data [BS];
    logic [31:0] lcg_state;
    int aw_wait, w_wait, b_wait, ar_wait, r_wait;
    int aw_n, w_n, b_n, ar_n, r_n;
    int max_delay, corrupt_blk, corrupt_beat;
    int blocks_done, ar_total, errors;
    bit fault_sent, false_alarm, watching, tie_reported;
    longint limit_ns;

    mem_test_top uut (.*);

    always #10 clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Ready delay in cycles for the next transfer
    function int next_delay();
        lcg_state = lcg_step(lcg_state);
        return int'(lcg_state[23:8]) % (max_delay + 1);
    endfunction

    // Checks in this module plus failed bound properties
    function automatic int error_count();
        return errors + uut.u_props.failures;
    endfunction

    function automatic bit tieoffs_ok();
        return m_axi_awlen == 8'd0 && m_axi_arlen == 8'd0
            && m_axi_awsize == BEAT_SIZE && m_axi_arsize == BEAT_SIZE
            && m_axi_awburst == 2'b01 && m_axi_arburst == 2'b01
            && m_axi_awid == 4'(`MT_AXI_ID) && m_axi_arid == 4'(`MT_AXI_ID)
            && m_axi_awcache == 4'(`MT_AXI_CACHE) && m_axi_arcache == 4'(`MT_AXI_CACHE)
            && m_axi_awprot == 3'(`MT_AWPROT) && m_axi_arprot == 3'(`MT_ARPROT)
            && m_axi_awlock == 1'b0 && m_axi_arlock == 1'b0
            && m_axi_awqos == 4'd0 && m_axi_arqos == 4'd0
            && m_axi_wlast == 1'b1 && m_axi_wstrb == '1;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        errors++;
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic report_event(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // ============================================================
    // AXI slave model and bus monitor
    // ============================================================
    always @(posedge clk) begin
        if (!M_AXI_ARESETN) begin
            m_axi_awready <= 1'b0;
            m_axi_wready  <= 1'b0;
            m_axi_bvalid  <= 1'b0;
            m_axi_arready <= 1'b0;
            m_axi_rvalid  <= 1'b0;
            aw_q.delete();
            w_q.delete();
            ar_q.delete();
            aw_n = 0;
            w_n = 0;
            b_n = 0;
            ar_n = 0;
            r_n = 0;
            aw_wait = next_delay();
            w_wait = next_delay();
            b_wait = next_delay();
            ar_wait = next_delay();
            r_wait = next_delay();
            blocks_done = 0;
            ar_total = 0;
            fault_sent = 0;
            false_alarm = 0;
        end else begin
            // A finished block rolls over on the first write of the next
            if (r_n == BS && ((m_axi_awvalid && m_axi_awready)
                              || (m_axi_wvalid && m_axi_wready))) begin
                aw_n = 0;
                w_n = 0;
                b_n = 0;
                ar_n = 0;
                r_n = 0;
            end

            // AW channel
            if (m_axi_awvalid && m_axi_awready) begin
                if (m_axi_awaddr[2:0] != 3'd0)
                    report_value("m_axi_awaddr[2:0]", m_axi_awaddr[2:0], 0);
                if (aw_n >= BS)
                    report_event("more AW beats than the block size");
                else begin
                    if (aw_n > 0 && m_axi_awaddr != blk_addr[aw_n-1] + BEAT_BYTES)
                        report_value("m_axi_awaddr", m_axi_awaddr,
                                     blk_addr[aw_n-1] + BEAT_BYTES);
                    blk_addr[aw_n] = m_axi_awaddr;
                end
                aw_q.push_back(m_axi_awaddr);
                aw_n++;
                m_axi_awready <= 1'b0;
                aw_wait = next_delay();
            end else if (m_axi_awvalid) begin
                if (aw_wait == 0) m_axi_awready <= 1'b1;
                else aw_wait--;
            end

            // W channel carrying data from a rising timer
            if (m_axi_wvalid && m_axi_wready) begin
                if (w_n >= BS)
                    report_event("more W beats than the block size");
                else begin
                    if (w_n > 0 && m_axi_wdata <= blk_data[w_n-1])
                        report_event("write data did not increase within the block");
                    blk_data[w_n] = m_axi_wdata;
                end
                w_q.push_back(m_axi_wdata);
                w_n++;
                m_axi_wready <= 1'b0;
                w_wait = next_delay();
            end else if (m_axi_wvalid) begin
                if (w_wait == 0) m_axi_wready <= 1'b1;
                else w_wait--;
            end

            // B channel once both halves of a write arrived
            if (m_axi_bvalid && m_axi_bready) begin
                m_axi_bvalid <= 1'b0;
                b_n++;
            end else if (!m_axi_bvalid && aw_q.size() > 0 && w_q.size() > 0) begin
                if (b_wait == 0) begin
                    mem[aw_q.pop_front()] = w_q.pop_front();
                    m_axi_bvalid <= 1'b1;
                    b_wait = next_delay();
                end else b_wait--;
            end

            // AR channel
            if (m_axi_arvalid && m_axi_arready) begin
                ar_total++;
                if (r_n == BS)
                    report_event("read issued where a new block should start with writes");
                if (aw_n != BS || w_n != BS || b_n != BS)
                    report_event("read started before all writes of the block completed");
                if (ar_n < BS && m_axi_araddr != blk_addr[ar_n])
                    report_value("m_axi_araddr", m_axi_araddr, blk_addr[ar_n]);
                ar_q.push_back(m_axi_araddr);
                ar_n++;
                m_axi_arready <= 1'b0;
                ar_wait = next_delay();
            end else if (m_axi_arvalid) begin
                if (ar_wait == 0) m_axi_arready <= 1'b1;
                else ar_wait--;
            end

            // R channel flips bit 0 on the selected beat
            if (m_axi_rvalid && m_axi_rready) begin
                if (r_n < BS && m_axi_rdata != (blk_data[r_n] ^ data_t'(fault_sent
                        && blocks_done == corrupt_blk && r_n == corrupt_beat)))
                    report_value("m_axi_rdata", m_axi_rdata, blk_data[r_n]);
                m_axi_rvalid <= 1'b0;
                r_n++;
                if (r_n == BS) blocks_done++;
            end else if (!m_axi_rvalid && ar_q.size() > 0) begin
                if (r_wait == 0) begin
                    if (!mem.exists(ar_q[0])) begin
                        report_event("read of an address that was never written");
                        m_axi_rdata <= '0;
                    end else if (blocks_done == corrupt_blk && r_n == corrupt_beat) begin
                        m_axi_rdata <= mem[ar_q[0]] ^ data_t'(1);
                        fault_sent = 1;
                    end else m_axi_rdata <= mem[ar_q[0]];
                    void'(ar_q.pop_front());
                    m_axi_rvalid <= 1'b1;
                    r_wait = next_delay();
                end else r_wait--;
            end

            if (watching && !fault_sent && alarm && !false_alarm) begin
                false_alarm = 1;
                report_event("alarm rose without a corrupted read");
            end
        end

        if (!tie_reported && !tieoffs_ok()) begin
            tie_reported = 1;
            report_event("a tie-off output differs from its fixed value");
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================
    task automatic run_test(input int num, input int nblk, input int maxd,
                            input int cblk, input int cbeat);
        int errs_before;
        int ar_before;
        int n;
        errs_before = error_count();
        max_delay = maxd;
        corrupt_blk = cblk;
        corrupt_beat = cbeat;

        @(posedge clk);
        M_AXI_ARESETN <= 1'b0;
        button <= 1'b0;
        repeat (3) @(posedge clk);
        M_AXI_ARESETN <= 1'b1;
        @(negedge clk);
        if (alarm !== 1'b1) report_value("alarm", alarm, 1);
        if ({m_axi_awvalid, m_axi_wvalid, m_axi_bready, m_axi_arvalid, m_axi_rready} !== 5'b0)
            report_value("valid/ready outputs",
                         {m_axi_awvalid, m_axi_wvalid, m_axi_bready,
                          m_axi_arvalid, m_axi_rready}, 0);

        @(posedge clk);
        button <= 1'b1;
        @(posedge clk);
        button <= 1'b0;
        @(negedge clk);
        if (alarm !== 1'b0) report_value("alarm", alarm, 0);
        watching = 1;

        if (cblk < nblk) begin
            while (!fault_sent) @(negedge clk);
            // The corrupted beat is the last read this block may issue
            ar_before = ar_total;
            n = 0;
            while (alarm !== 1'b1 && n < 20) begin
                @(negedge clk);
                n++;
            end
            if (alarm !== 1'b1) report_event("alarm did not rise after the corrupted read");
            repeat (50) @(posedge clk);
            @(negedge clk);
            if (ar_total != ar_before) report_event("AR handshake after the corrupted read");
            if (alarm !== 1'b1) report_value("alarm", alarm, 1);
        end else begin
            while (blocks_done < nblk) @(negedge clk);
            if (alarm !== 1'b0) report_value("alarm", alarm, 0);
        end
        watching = 0;

        if (error_count() == errs_before)
            $display("test %0d: %0d blocks, delay %0d, ok", num, nblk, maxd);
        else
            $display("test %0d: %0d blocks, delay %0d, %0d errors",
                     num, nblk, maxd, error_count() - errs_before);
    endtask

    int t_num [$];
    int t_blk [$];
    int t_dly [$];
    int t_cb [$];
    int t_cbeat [$];

    initial begin
        int fd;
        int a, b, c, d, e;
        int passed;
        string line;
        clk = 1'b0;
        M_AXI_ARESETN = 1'b0;
        button = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready = 1'b0;
        m_axi_bvalid = 1'b0;
        m_axi_bresp = 2'b00;
        m_axi_arready = 1'b0;
        m_axi_rvalid = 1'b0;
        m_axi_rdata = '0;
        m_axi_rresp = 2'b00;
        m_axi_rlast = 1'b1;
        lcg_state = 32'h28a4_4a96;
        errors = 0;
        passed = 0;
        limit_ns = 0;

        fd = $fopen("verification/mem_test_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the test input file");
            $display("** FAIL **");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#"
                    && $sscanf(line, "%h %h %h %h %h", a, b, c, d, e) == 5) begin
                    t_num.push_back(a);
                    t_blk.push_back(b);
                    t_dly.push_back(c);
                    t_cb.push_back(d);
                    t_cbeat.push_back(e);
                    limit_ns += longint'(b) * 2 * BS * (c + 6) * 20;
                end
            end
            $fclose(fd);
            limit_ns += 50000;

            foreach (t_num[i]) begin
                a = error_count();
                run_test(t_num[i], t_blk[i], t_dly[i], t_cb[i], t_cbeat[i]);
                if (error_count() == a) passed++;
            end

            $display("tests run: %0d, passed: %0d, failed: %0d",
                     t_num.size(), passed, t_num.size() - passed);
            if (error_count() == 0 && t_num.size() > 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    // Watchdog limit comes from the test lengths read above
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("ERROR: watchdog timeout, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verification/mem_test_props.sv */
`timescale 1ns/1ps

module mem_test_props (
    input logic                clk,
    input logic                M_AXI_ARESETN,
    input logic                button,
    input logic                alarm,
    input mem_test_pkg::addr_t m_axi_awaddr,
    input logic                m_axi_awvalid,
    input logic                m_axi_awready,
    input mem_test_pkg::data_t m_axi_wdata,
    input logic                m_axi_wvalid,
    input logic                m_axi_wready,
    input logic                m_axi_bready,
    input mem_test_pkg::addr_t m_axi_araddr,
    input logic                m_axi_arvalid,
    input logic                m_axi_arready
);

    // Number of property failures so far
    int failures;

    // Valid held with a stable payload until ready
    assert property (@(posedge clk) disable iff (!M_AXI_ARESETN)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
        else begin
            failures++;
            $error("AW valid or address changed before ready");
        end
    assert property (@(posedge clk) disable iff (!M_AXI_ARESETN)
        m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
        else begin
            failures++;
            $error("W valid or data changed before ready");
        end
    assert property (@(posedge clk) disable iff (!M_AXI_ARESETN)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
        else begin
            failures++;
            $error("AR valid or address changed before ready");
        end

    // Alarm only clears on the button
    assert property (@(posedge clk) disable iff (!M_AXI_ARESETN)
        $fell(alarm) |-> $past(button))
        else begin
            failures++;
            $error("alarm fell without a button press");
        end

    // No read address while BREADY marks a write in flight
    assert property (@(posedge clk) disable iff (!M_AXI_ARESETN)
        m_axi_arvalid |-> !m_axi_bready)
        else begin
            failures++;
            $error("AR issued while a write is outstanding");
        end

endmodule

bind mem_test_top mem_test_props u_props (.*);

/* source/mem_test_top.sv */
`timescale 1ns/1ps

`include "mem_test_cfg.svh"

module mem_test_top (
    input  logic                clk,
    input  logic                M_AXI_ARESETN,
    input  logic                button,
    output logic                alarm,
    // Write address channel
    output mem_test_pkg::addr_t m_axi_awaddr,
    output logic                m_axi_awvalid,
    input  logic                m_axi_awready,
    output logic [2:0]          m_axi_awprot,
    output logic [3:0]          m_axi_awid,
    output logic [7:0]          m_axi_awlen,
    output logic [2:0]          m_axi_awsize,
    output logic [1:0]          m_axi_awburst,
    output logic                m_axi_awlock,
    output logic [3:0]          m_axi_awcache,
    output logic [3:0]          m_axi_awqos,
    // Write data channel
    output mem_test_pkg::data_t m_axi_wdata,
    output mem_test_pkg::strb_t m_axi_wstrb,
    output logic                m_axi_wvalid,
    output logic                m_axi_wlast,
    input  logic                m_axi_wready,
    // Write response channel
    input  logic [1:0]          m_axi_bresp,
    input  logic                m_axi_bvalid,
    output logic                m_axi_bready,
    // Read address channel
    output mem_test_pkg::addr_t m_axi_araddr,
    output logic                m_axi_arvalid,
    input  logic                m_axi_arready,
    output logic [2:0]          m_axi_arprot,
    output logic [3:0]          m_axi_arid,
    output logic [7:0]          m_axi_arlen,
    output logic [2:0]          m_axi_arsize,
    output logic [1:0]          m_axi_arburst,
    output logic                m_axi_arlock,
    output logic [3:0]          m_axi_arcache,
    output logic [3:0]          m_axi_arqos,
    // Read data channel, response and last flag are not inspected
    input  mem_test_pkg::data_t m_axi_rdata,
    input  logic [1:0]          m_axi_rresp,
    input  logic                m_axi_rvalid,
    input  logic                m_axi_rlast,
    output logic                m_axi_rready
);
    import mem_test_pkg::*;

    // ============================================================
    // Fixed single-beat AXI4 signalling
    // ============================================================
    assign m_axi_awid    = 4'(`MT_AXI_ID);
    assign m_axi_awlen   = 8'd0;
    assign m_axi_awsize  = BEAT_SIZE;
    // Incrementing burst type
    assign m_axi_awburst = 2'b01;
    assign m_axi_awlock  = 1'b0;
    assign m_axi_awcache = 4'(`MT_AXI_CACHE);
    assign m_axi_awqos   = 4'd0;
    assign m_axi_awprot  = 3'(`MT_AWPROT);
    // Every beat is whole and the last of its burst
    assign m_axi_wstrb   = '1;
    assign m_axi_wlast   = 1'b1;

    assign m_axi_arid    = 4'(`MT_AXI_ID);
    assign m_axi_arlen   = 8'd0;
    assign m_axi_arsize  = BEAT_SIZE;
    assign m_axi_arburst = 2'b01;
    assign m_axi_arlock  = 1'b0;
    assign m_axi_arcache = 4'(`MT_AXI_CACHE);
    assign m_axi_arqos   = 4'd0;
    assign m_axi_arprot  = 3'(`MT_ARPROT);

    // Request channels between the sequencer and the engines
    amci_write_if wr_if ();
    amci_read_if  rd_if ();

    block_checker u_checker (
        .clk           (clk),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .button        (button),
        .alarm         (alarm),
        .wr            (wr_if.requester),
        .rd            (rd_if.requester)
    );

    axi_write_engine u_write (
        .clk           (clk),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .req           (wr_if.engine),
        .awaddr        (m_axi_awaddr),
        .awvalid       (m_axi_awvalid),
        .awready       (m_axi_awready),
        .wdata         (m_axi_wdata),
        .wvalid        (m_axi_wvalid),
        .wready        (m_axi_wready),
        .bvalid        (m_axi_bvalid),
        .bready        (m_axi_bready)
    );

    axi_read_engine u_read (
        .clk           (clk),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .req           (rd_if.engine),
        .araddr        (m_axi_araddr),
        .arvalid       (m_axi_arvalid),
        .arready       (m_axi_arready),
        .rdata_axi     (m_axi_rdata),
        .rvalid        (m_axi_rvalid),
        .rready        (m_axi_rready)
    );

endmodule

/* source/block_checker.sv */
`timescale 1ns/1ps

`include "mem_test_cfg.svh"

module block_checker (
    input  logic            clk,
    input  logic            M_AXI_ARESETN,
    input  logic            button,
    output logic            alarm,
    amci_write_if.requester wr,
    amci_read_if.requester  rd
);
    import mem_test_pkg::*;

    typedef enum logic [1:0] {
        S_WAIT_BUTTON,
        S_START_BLOCK,
        S_WRITE,
        S_READ
    } state_t;

    localparam index_t BLOCK_BEATS = index_t'(`MT_BLOCK_SIZE);
    localparam index_t LAST_INDEX  = index_t'(`MT_BLOCK_SIZE - 1);

    state_t state;
    index_t index;

    // Free-running sources for base address and beat data
    addr_t  addr_counter;
    data_t  free_timer;

    // Local copy of the block as written
    data_t  shadow [`MT_BLOCK_SIZE];
    addr_t  first_addr;

    logic   start_blk;
    logic   next_wr;
    logic   first_rd;
    logic   rd_done;
    logic   match;
    logic   next_rd;
    logic   block_ok;

    // ============================================================
    // Sequencing strobes
    // ============================================================
    assign start_blk = (state == S_START_BLOCK) && wr.widle;
    assign next_wr   = (state == S_WRITE) && wr.widle && (index != BLOCK_BEATS);
    assign first_rd  = (state == S_WRITE) && wr.widle && (index == BLOCK_BEATS);

    // Once the alarm is set no further read results are taken
    assign rd_done   = (state == S_READ) && rd.ridle && !alarm;
    assign match     = (rd.rdata == shadow[index[$clog2(`MT_BLOCK_SIZE)-1:0]]);
    assign next_rd   = rd_done && match && (index != LAST_INDEX);
    assign block_ok  = rd_done && match && (index == LAST_INDEX);

    // Address steps one beat per cycle so each block lands somewhere new
    always_ff @(posedge clk) begin
        if (!M_AXI_ARESETN) begin
            addr_counter <= '0;
            free_timer   <= '0;
        end else begin
            addr_counter <= addr_counter + BEAT_BYTES;
            free_timer   <= free_timer + data_t'(1);
        end
    end

    // ============================================================
    // Test FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (!M_AXI_ARESETN) begin
            state    <= S_WAIT_BUTTON;
            index    <= '0;
            alarm    <= 1'b1;
            wr.write <= 1'b0;
            rd.read  <= 1'b0;
        end else begin
            // Start requests are single-cycle pulses
            wr.write <= 1'b0;
            rd.read  <= 1'b0;
            case (state)
                S_WAIT_BUTTON: begin
                    if (button) begin
                        alarm <= 1'b0;
                        index <= '0;
                        state <= S_START_BLOCK;
                    end
                end
                // First beat of a new block
                S_START_BLOCK: begin
                    if (start_blk) begin
                        wr.write <= 1'b1;
                        index    <= index_t'(1);
                        state    <= S_WRITE;
                    end
                end
                // Remaining beats, then the first read of the block
                S_WRITE: begin
                    if (first_rd) begin
                        rd.read <= 1'b1;
                        index   <= '0;
                        state   <= S_READ;
                    end else if (next_wr) begin
                        wr.write <= 1'b1;
                        index    <= index + index_t'(1);
                    end
                end
                // Compare each returned word and stop on the first mismatch
                S_READ: begin
                    if (rd_done) begin
                        if (!match) begin
                            alarm <= 1'b1;
                        end else if (block_ok) begin
                            index <= '0;
                            state <= S_START_BLOCK;
                        end else begin
                            rd.read <= 1'b1;
                            index   <= index + index_t'(1);
                        end
                    end
                end
                default: state <= S_WAIT_BUTTON;
            endcase
        end
    end

    // ============================================================
    // Request payloads and shadow buffer
    // ============================================================
    always_ff @(posedge clk) begin
        if (start_blk) begin
            first_addr <= addr_counter;
            wr.waddr   <= addr_counter;
            wr.wdata   <= free_timer;
        end else if (next_wr) begin
            wr.waddr <= wr.waddr + BEAT_BYTES;
            wr.wdata <= free_timer;
        end

        // Index is zero at block start, so one store covers both cases
        if (start_blk || next_wr) begin
            shadow[index[$clog2(`MT_BLOCK_SIZE)-1:0]] <= free_timer;
        end

        // Reads walk the block from its base in write order
        if (first_rd) begin
            rd.raddr <= first_addr;
        end else if (next_rd) begin
            rd.raddr <= rd.raddr + BEAT_BYTES;
        end
    end

endmodule

/* source/axi_read_engine.sv */
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                clk,
    input  logic                M_AXI_ARESETN,
    amci_read_if.engine         req,
    output mem_test_pkg::addr_t araddr,
    output logic                arvalid,
    input  logic                arready,
    input  mem_test_pkg::data_t rdata_axi,
    input  logic                rvalid,
    output logic                rready
);

    typedef enum logic {
        R_IDLE,
        R_BUSY
    } rstate_t;

    rstate_t state;

    logic ar_hs;
    logic r_hs;
    logic start;

    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;
    assign start = (state == R_IDLE) && req.read;

    // Low while busy and in the cycle of the start pulse
    assign req.ridle = (state == R_IDLE) && !req.read;

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (!M_AXI_ARESETN) begin
            state   <= R_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (start) begin
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        state   <= R_BUSY;
                    end
                end
                // Address goes first, data ends the transfer
                R_BUSY: begin
                    if (ar_hs) begin
                        arvalid <= 1'b0;
                    end
                    if (r_hs) begin
                        rready <= 1'b0;
                        state  <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Address taken at the start pulse, data captured on the R handshake
    always_ff @(posedge clk) begin
        if (start) begin
            araddr <= req.raddr;
        end
        if (r_hs) begin
            req.rdata <= rdata_axi;
        end
    end

endmodule

/* source/axi_write_engine.sv */
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                clk,
    input  logic                M_AXI_ARESETN,
    amci_write_if.engine        req,
    output mem_test_pkg::addr_t awaddr,
    output logic                awvalid,
    input  logic                awready,
    output mem_test_pkg::data_t wdata,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR_DATA,
        W_RESP
    } wstate_t;

    wstate_t state;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic aw_done;
    logic w_done;
    logic start;

    // Channel handshakes
    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign b_hs  = bvalid & bready;

    // A channel is finished once its valid has dropped or drops this cycle
    assign aw_done = ~awvalid | aw_hs;
    assign w_done  = ~wvalid | w_hs;

    assign start = (state == W_IDLE) && req.write;

    // Busy from the start pulse onward
    assign req.widle = (state == W_IDLE) && !req.write;

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (!M_AXI_ARESETN) begin
            state   <= W_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            case (state)
                // Present address and data, accept the response early
                W_IDLE: begin
                    if (start) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        bready  <= 1'b1;
                        state   <= W_ADDR_DATA;
                    end
                end
                // AW and W may be accepted in either order
                W_ADDR_DATA: begin
                    if (aw_hs) begin
                        awvalid <= 1'b0;
                    end
                    if (w_hs) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= W_RESP;
                    end
                end
                // Response code is not inspected
                W_RESP: begin
                    if (b_hs) begin
                        bready <= 1'b0;
                        state  <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Payload held stable from the start pulse until the next request
    always_ff @(posedge clk) begin
        if (start) begin
            awaddr <= req.waddr;
            wdata  <= req.wdata;
        end
    end

endmodule

/* source/amci_if.sv */
`timescale 1ns/1ps

// Write request channel between the checker and the write engine
interface amci_write_if;
    import mem_test_pkg::*;

    addr_t waddr;
    data_t wdata;
    // One-cycle start pulse
    logic  write;
    // High when the engine can take a new request
    logic  widle;

    modport requester (
        output waddr,
        output wdata,
        output write,
        input  widle
    );

    modport engine (
        input  waddr,
        input  wdata,
        input  write,
        output widle
    );
endinterface

// Read request channel between the checker and the read engine
interface amci_read_if;
    import mem_test_pkg::*;

    addr_t raddr;
    logic  read;
    logic  ridle;
    // Valid once ridle returns high
    data_t rdata;

    modport requester (
        output raddr,
        output read,
        input  ridle,
        input  rdata
    );

    modport engine (
        input  raddr,
        input  read,
        output ridle,
        output rdata
    );
endinterface

/* source/mem_test_pkg.sv */
`include "mem_test_cfg.svh"

package mem_test_pkg;

    // ============================================================
    // Bus payload types
    // ============================================================

    typedef logic [`MT_AXI_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`MT_AXI_DATA_WIDTH-1:0]   data_t;
    typedef logic [`MT_AXI_DATA_WIDTH/8-1:0] strb_t;

    // Beat index within a block, one extra count for the end marker
    typedef logic [$clog2(`MT_BLOCK_SIZE+1)-1:0] index_t;

    // ============================================================
    // Derived beat constants
    // ============================================================

    // Address stride between consecutive beats
    localparam addr_t BEAT_BYTES = addr_t'(`MT_AXI_DATA_WIDTH / 8);

    // AXI size code for a full-width beat
    localparam logic [2:0] BEAT_SIZE = 3'($clog2(`MT_AXI_DATA_WIDTH / 8));

endpackage

/* source/mem_test_cfg.svh */
`ifndef MEM_TEST_CFG_SVH
`define MEM_TEST_CFG_SVH

// AXI bus geometry
`define MT_AXI_DATA_WIDTH 64
`define MT_AXI_ADDR_WIDTH 34

// Beats written and then read back per test block
`define MT_BLOCK_SIZE 16

// Fixed transaction ID on both AW and AR
`define MT_AXI_ID 1

// Normal, no cache, no buffer
`define MT_AXI_CACHE 2

// Protection values for each direction
`define MT_AWPROT 0
`define MT_ARPROT 1

`endif
